// ==== include/stopwatch_params.svh ====
`ifndef STOPWATCH_PARAMS_SVH
`define STOPWATCH_PARAMS_SVH

// clock cycles per hundredth of a second at 100 MHz
`define SW_TICK_DIV 1000000

// flops per button synchronizer chain
`define SW_SYNC_STAGES 2

`endif

// ==== source/stopwatch_pkg.sv ====
`default_nettype none

package stopwatch_pkg;

  typedef enum logic [2:0] {
    MODE_HALT    = 3'd0,
    MODE_RUN     = 3'd1,
    MODE_EDIT_D0 = 3'd2,
    MODE_EDIT_D1 = 3'd3,
    MODE_EDIT_D2 = 3'd4,
    MODE_EDIT_D3 = 3'd5
  } sw_mode_e;

  // one-cycle press pulses
  typedef struct packed {
    logic start_stop;
    logic set;
    logic change;
  } btn_events_t;

  // d3 tens of seconds .. d0 hundredths
  typedef struct packed {
    logic [3:0] d3;
    logic [3:0] d2;
    logic [3:0] d1;
    logic [3:0] d0;
  } time_bcd_t;

  // active low patterns with bit 0 as segment a
  typedef struct packed {
    logic [6:0] hex3;
    logic [6:0] hex2;
    logic [6:0] hex1;
    logic [6:0] hex0;
  } seg7_bus_t;

endpackage

`default_nettype wire

// ==== source/button_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stopwatch_params.svh"

module button_conditioner
  import stopwatch_pkg::*;
(
  input  wire         clk100_i,
  input  wire         rstn_i,
  input  wire         start_stop_i,
  input  wire         set_i,
  input  wire         change_i,
  output btn_events_t events_o
);

  localparam int n_btn = $bits(btn_events_t);

  btn_events_t      raw_lvl;
  logic [n_btn-1:0] press_vec;

  assign raw_lvl.start_stop = start_stop_i;
  assign raw_lvl.set        = set_i;
  assign raw_lvl.change     = change_i;

  for (genvar i = 0; i < n_btn; i++) begin : g_btn
    logic [`SW_SYNC_STAGES-1:0] sync_q;
    logic                       hist_q;
    logic                       press_q;
    logic                       sync_lvl;

    assign sync_lvl = sync_q[`SW_SYNC_STAGES-1];

    always_ff @(posedge clk100_i or negedge rstn_i) begin
      if (!rstn_i) begin
        sync_q  <= '0;
        hist_q  <= 1'b0;
        press_q <= 1'b0;
      end else begin
        sync_q  <= {sync_q[`SW_SYNC_STAGES-2:0], raw_lvl[i]};
        hist_q  <= sync_lvl;
        // rising edge of the synchronized level
        press_q <= sync_lvl & ~hist_q;
      end
    end

    assign press_vec[i] = press_q;
  end

  assign events_o = btn_events_t'(press_vec);

endmodule

`default_nettype wire

// ==== source/centisecond_ticker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stopwatch_params.svh"

module centisecond_ticker #(
  parameter int tick_div = `SW_TICK_DIV
) (
  input  wire  clk100_i,
  input  wire  rstn_i,
  input  wire  run_i,
  output logic tick_o
);

  localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(tick_div - 1);

  logic [cnt_w-1:0] cnt_q;
  logic             wrap;

  assign wrap = (cnt_q == cnt_last);

  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (!run_i) begin
      // prescaler held at zero while stopped
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else begin
      tick_o <= wrap;
      if (wrap) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/time_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module time_keeper
  import stopwatch_pkg::*;
(
  input  wire              clk100_i,
  input  wire              rstn_i,
  input  wire btn_events_t events_i,
  input  wire              tick_i,
  output logic             run_o,
  output time_bcd_t        time_o
);

  sw_mode_e  mode_q;
  sw_mode_e  mode_d;
  time_bcd_t time_q;
  time_bcd_t time_d;
  logic      count_en;
  logic [3:0] carry;

  function automatic logic [3:0] bcd_inc(input logic [3:0] digit);
    logic [3:0] next;
    if (digit >= 4'd9) begin
      next = 4'd0;
    end else begin
      next = digit + 4'd1;
    end
    return next;
  endfunction

  always_comb begin
    mode_d = mode_q;
    case (mode_q)
      MODE_HALT: begin
        if (events_i.start_stop) begin
          mode_d = MODE_RUN;
        end else if (events_i.set) begin
          mode_d = MODE_EDIT_D0;
        end
      end
      MODE_RUN: begin
        // set is ignored while counting
        if (events_i.start_stop) begin
          mode_d = MODE_HALT;
        end
      end
      MODE_EDIT_D0: begin
        if (events_i.set) begin
          mode_d = MODE_EDIT_D1;
        end
      end
      MODE_EDIT_D1: begin
        if (events_i.set) begin
          mode_d = MODE_EDIT_D2;
        end
      end
      MODE_EDIT_D2: begin
        if (events_i.set) begin
          mode_d = MODE_EDIT_D3;
        end
      end
      MODE_EDIT_D3: begin
        if (events_i.set) begin
          mode_d = MODE_HALT;
        end
      end
      default: begin
        mode_d = MODE_HALT;
      end
    endcase
  end

  // carry[i] advances digit i
  assign count_en = (mode_q == MODE_RUN) && tick_i;
  assign carry[0] = count_en;
  assign carry[1] = carry[0] && (time_q.d0 == 4'd9);
  assign carry[2] = carry[1] && (time_q.d1 == 4'd9);
  assign carry[3] = carry[2] && (time_q.d2 == 4'd9);

  always_comb begin
    time_d = time_q;
    if (carry[0]) begin
      time_d.d0 = bcd_inc(time_q.d0);
    end
    if (carry[1]) begin
      time_d.d1 = bcd_inc(time_q.d1);
    end
    if (carry[2]) begin
      time_d.d2 = bcd_inc(time_q.d2);
    end
    // d3 wraps too, so 99.99 rolls to 00.00
    if (carry[3]) begin
      time_d.d3 = bcd_inc(time_q.d3);
    end
    // edit increments never carry
    if (events_i.change) begin
      case (mode_q)
        MODE_EDIT_D0: time_d.d0 = bcd_inc(time_q.d0);
        MODE_EDIT_D1: time_d.d1 = bcd_inc(time_q.d1);
        MODE_EDIT_D2: time_d.d2 = bcd_inc(time_q.d2);
        MODE_EDIT_D3: time_d.d3 = bcd_inc(time_q.d3);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      mode_q <= MODE_HALT;
      time_q <= '0;
    end else begin
      mode_q <= mode_d;
      time_q <= time_d;
    end
  end

  assign run_o  = (mode_q == MODE_RUN);
  assign time_o = time_q;

endmodule

`default_nettype wire

// ==== source/seg7_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg7_display
  import stopwatch_pkg::*;
(
  input  wire time_bcd_t time_i,
  output seg7_bus_t      segs_o
);

  // active low patterns with bit 6 as segment g
  function automatic logic [6:0] seg7_encode(input logic [3:0] digit);
    logic [6:0] pattern;
    case (digit)
      4'd0:    pattern = 7'b1000000;
      4'd1:    pattern = 7'b1111001;
      4'd2:    pattern = 7'b0100100;
      4'd3:    pattern = 7'b0110000;
      4'd4:    pattern = 7'b0011001;
      4'd5:    pattern = 7'b0010010;
      4'd6:    pattern = 7'b0000010;
      4'd7:    pattern = 7'b1111000;
      4'd8:    pattern = 7'b0000000;
      4'd9:    pattern = 7'b0010000;
      // blank for non-BCD values
      default: pattern = 7'b1111111;
    endcase
    return pattern;
  endfunction

  always_comb begin
    segs_o.hex0 = seg7_encode(time_i.d0);
    segs_o.hex1 = seg7_encode(time_i.d1);
    segs_o.hex2 = seg7_encode(time_i.d2);
    segs_o.hex3 = seg7_encode(time_i.d3);
  end

endmodule

`default_nettype wire

// ==== source/stopwatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stopwatch_params.svh"

module stopwatch
  import stopwatch_pkg::*;
#(
  parameter int tick_div = `SW_TICK_DIV
) (
  input  wire        clk100_i,
  input  wire        rstn_i,
  input  wire        start_stop_i,
  input  wire        set_i,
  input  wire        change_i,
  output logic [6:0] hex0_o,
  output logic [6:0] hex1_o,
  output logic [6:0] hex2_o,
  output logic [6:0] hex3_o
);

  btn_events_t events;
  logic        run;
  logic        tick;
  time_bcd_t   time_bcd;
  seg7_bus_t   segs;

  button_conditioner u_btn (
    .clk100_i     (clk100_i),
    .rstn_i       (rstn_i),
    .start_stop_i (start_stop_i),
    .set_i        (set_i),
    .change_i     (change_i),
    .events_o     (events)
  );

  centisecond_ticker #(
    .tick_div (tick_div)
  ) u_ticker (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .run_i    (run),
    .tick_o   (tick)
  );

  time_keeper u_keeper (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .events_i (events),
    .tick_i   (tick),
    .run_o    (run),
    .time_o   (time_bcd)
  );

  seg7_display u_disp (
    .time_i (time_bcd),
    .segs_o (segs)
  );

  assign hex0_o = segs.hex0;
  assign hex1_o = segs.hex1;
  assign hex2_o = segs.hex2;
  assign hex3_o = segs.hex3;

endmodule

`default_nettype wire

// ==== tb/stopwatch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stopwatch_checker
  import stopwatch_pkg::*;
(
  input  wire              clk100_i,
  input  wire              rstn_i,
  input  wire              check_i,
  input  wire time_bcd_t   exp_i,
  input  wire [8*16-1:0]   name_i,
  input  wire [6:0]        hex0_i,
  input  wire [6:0]        hex1_i,
  input  wire [6:0]        hex2_i,
  input  wire [6:0]        hex3_i,
  output int               pass_cnt_o,
  output int               err_cnt_o
);

  logic [27:0] exp_segs;
  logic [27:0] act_segs;

  // lit segments listed as g..a, then inverted for the active-low display
  function automatic logic [6:0] digit_pattern(input logic [3:0] digit);
    logic [6:0] lit;
    case (digit)
      4'd0:    lit = 7'b0111111;
      4'd1:    lit = 7'b0000110;
      4'd2:    lit = 7'b1011011;
      4'd3:    lit = 7'b1001111;
      4'd4:    lit = 7'b1100110;
      4'd5:    lit = 7'b1101101;
      4'd6:    lit = 7'b1111101;
      4'd7:    lit = 7'b0000111;
      4'd8:    lit = 7'b1111111;
      4'd9:    lit = 7'b1101111;
      default: lit = 7'b0000000;
    endcase
    return ~lit;
  endfunction

  assign exp_segs = {digit_pattern(exp_i.d3), digit_pattern(exp_i.d2),
                     digit_pattern(exp_i.d1), digit_pattern(exp_i.d0)};
  assign act_segs = {hex3_i, hex2_i, hex1_i, hex0_i};

  always @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      pass_cnt_o <= 0;
      err_cnt_o  <= 0;
    end else if (check_i) begin
      if (act_segs === exp_segs) begin
        $display("pass %0s: display %h", name_i, exp_i);
        pass_cnt_o <= pass_cnt_o + 1;
      end else begin
        $display("mismatch %0s: expected %h (segs %b) actual segs %b",
                 name_i, exp_i, exp_segs, act_segs);
        err_cnt_o <= err_cnt_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_stopwatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_stopwatch
  import stopwatch_pkg::*;
();

  localparam int tick_div = 8;
  localparam int n_rows   = 22;

  typedef enum logic [1:0] {
    ACT_WAIT,
    ACT_START,
    ACT_SET,
    ACT_CHANGE
  } action_e;

  logic            clk100;
  logic            rstn;
  logic            start_stop;
  logic            set_btn;
  logic            change;
  logic [6:0]      hex0;
  logic [6:0]      hex1;
  logic [6:0]      hex2;
  logic [6:0]      hex3;
  logic            check_q;
  time_bcd_t       exp_q;
  logic [8*16-1:0] name_q;
  int              pass_cnt;
  int              err_cnt;
  int              cycle_cnt;
  int              cycle_limit;
  logic [31:0]     lfsr_state;

  logic [8*16-1:0] row_name [n_rows];
  action_e         row_act [n_rows];
  int              row_reps [n_rows];
  int              row_cycles [n_rows];
  time_bcd_t       row_exp [n_rows];
  int              row_cnt;

  stopwatch #(
    .tick_div (tick_div)
  ) u_dut (
    .clk100_i     (clk100),
    .rstn_i       (rstn),
    .start_stop_i (start_stop),
    .set_i        (set_btn),
    .change_i     (change),
    .hex0_o       (hex0),
    .hex1_o       (hex1),
    .hex2_o       (hex2),
    .hex3_o       (hex3)
  );

  stopwatch_checker u_chk (
    .clk100_i   (clk100),
    .rstn_i     (rstn),
    .check_i    (check_q),
    .exp_i      (exp_q),
    .name_i     (name_q),
    .hex0_i     (hex0),
    .hex1_i     (hex1),
    .hex2_i     (hex2),
    .hex3_i     (hex3),
    .pass_cnt_o (pass_cnt),
    .err_cnt_o  (err_cnt)
  );

  initial begin
    clk100 = 1'b0;
    forever #50 clk100 = ~clk100;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_hold(output int len);
    logic [2:0] bits;
    for (int b = 0; b < 3; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits[b]    = lfsr_state[0];
    end
    len = 3 + int'(bits);
  endtask

  task automatic add_row(input logic [8*16-1:0] name, input action_e act,
                         input int reps, input int cycles, input logic [15:0] digits);
    row_name[row_cnt]   = name;
    row_act[row_cnt]    = act;
    row_reps[row_cnt]   = reps;
    row_cycles[row_cnt] = cycles;
    row_exp[row_cnt]    = digits;
    row_cnt             = row_cnt + 1;
    // budget 16 extra cycles per press on top of the row length
    cycle_limit = cycle_limit + 2 * reps * cycles;
    if (act != ACT_WAIT) begin
      cycle_limit = cycle_limit + 2 * 16 * reps;
    end
  endtask

  // running spans are n*8+4 cycles from one start edge to the next
  task automatic build_table();
    row_cnt     = 0;
    cycle_limit = 2 * 5;
    add_row("reset_zero",  ACT_WAIT,    1,  20, 16'h0000);
    add_row("run1_start",  ACT_START,   1, 108, 16'h0012);
    add_row("run1_stop",   ACT_START,   1,  40, 16'h0013);
    add_row("halt_wait",   ACT_WAIT,    1, 400, 16'h0013);
    add_row("halt_change", ACT_CHANGE,  1,  40, 16'h0013);
    add_row("run2_start",  ACT_START,   1, 300, 16'h0049);
    add_row("run_change",  ACT_CHANGE,  1, 200, 16'h0074);
    add_row("run_set",     ACT_SET,     1, 224, 16'h0102);
    add_row("run2_stop",   ACT_START,   1,  40, 16'h0103);
    add_row("edit_d0",     ACT_SET,     1,  40, 16'h0103);
    add_row("edit_d0_x3",  ACT_CHANGE,  3,  30, 16'h0106);
    add_row("edit_d0_x3b", ACT_CHANGE,  3,  30, 16'h0109);
    add_row("edit_d1",     ACT_SET,     1,  40, 16'h0109);
    add_row("edit_d1_x12", ACT_CHANGE, 12,  30, 16'h0129);
    add_row("edit_d1_x7",  ACT_CHANGE,  7,  30, 16'h0199);
    add_row("edit_d2",     ACT_SET,     1,  40, 16'h0199);
    add_row("edit_d2_x8",  ACT_CHANGE,  8,  30, 16'h0999);
    add_row("edit_d3",     ACT_SET,     1,  40, 16'h0999);
    add_row("edit_d3_x9",  ACT_CHANGE,  9,  30, 16'h9999);
    add_row("edit_exit",   ACT_SET,     1,  40, 16'h9999);
    add_row("roll_start",  ACT_START,   1,  20, 16'h0000);
    add_row("roll_stop",   ACT_START,   1,  40, 16'h0001);
  endtask

  task automatic drive_button(input action_e act, input logic level);
    case (act)
      ACT_START:  start_stop <= level;
      ACT_SET:    set_btn    <= level;
      ACT_CHANGE: change     <= level;
      default: ;
    endcase
  endtask

  // strobe the checker on the last cycle of the row
  task automatic run_row(input int idx);
    int hold;
    for (int r = 0; r < row_reps[idx]; r++) begin
      pick_hold(hold);
      for (int c = 0; c < row_cycles[idx]; c++) begin
        @(posedge clk100);
        drive_button(row_act[idx], c < hold);
        check_q <= (r == row_reps[idx] - 1) && (c == row_cycles[idx] - 1);
        exp_q   <= row_exp[idx];
        name_q  <= row_name[idx];
      end
    end
  endtask

  always @(posedge clk100) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    rstn       = 1'b0;
    start_stop = 1'b0;
    set_btn    = 1'b0;
    change     = 1'b0;
    check_q    = 1'b0;
    exp_q      = '0;
    name_q     = '0;
    cycle_cnt  = 0;
    lfsr_state = 32'hdbf9;
    build_table();
    repeat (5) @(posedge clk100);
    rstn <= 1'b1;
    for (int i = 0; i < row_cnt; i++) begin
      run_row(i);
    end
    @(posedge clk100);
    check_q <= 1'b0;
    @(posedge clk100);
    if (pass_cnt + err_cnt != row_cnt) begin
      $display("error: only %0d of %0d tests were checked", pass_cnt + err_cnt, row_cnt);
    end
    $display("tests run %0d, passed %0d, failed %0d", row_cnt, pass_cnt, err_cnt);
    if (err_cnt == 0 && pass_cnt == row_cnt) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/stopwatch_pkg.sv
source/button_conditioner.sv
source/centisecond_ticker.sv
source/time_keeper.sv
source/seg7_display.sv
source/stopwatch.sv
tb/stopwatch_checker.sv
tb/tb_stopwatch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the stopwatch testbench with Verilator
set -u
set -o pipefail

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -f tb.f --top-module tb_stopwatch -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log \
  || { echo "build or simulation run failed"; exit 1; }

# the log decides the result
grep -q "\*\* FAIL \*\*" sim.log \
  && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation finished without failure"; exit 0; }
